// File: design/usb_rx_pkg.sv
/*
 * Shared constants for the full-speed USB receiver: line-state codes, sync and
 * idle history patterns, PID groups, CRC polynomials and field widths.
 * Design and testbench refer to them by scoped name.
 */
package usb_rx_pkg;

  // full speed is sampled four times per bit, which sets the bit-phase counter
  localparam int unsigned SAMPLES_PER_BIT = 4;

  // filtered line state, bit 2 marks the one-clock transition window
  typedef logic [2:0] line_state_t;

  localparam line_state_t LINE_DT  = 3'b100;
  localparam line_state_t LINE_J   = 3'b010;
  localparam line_state_t LINE_K   = 3'b001;
  localparam line_state_t LINE_SE0 = 3'b000;

  // six symbols of two bits each, the newest in the low bits
  // the sync field ends with KJKJKK
  localparam logic [11:0] SYNC_PATTERN = 12'b01_10_01_10_01_01;
  // an idle bus is a run of J symbols
  localparam logic [11:0] IDLE_HISTORY = 12'b10_10_10_10_10_10;

  // the low two PID bits select the packet group
  localparam int unsigned PID_W = 4;
  localparam logic [1:0] PID_GROUP_TOKEN     = 2'b01;
  localparam logic [1:0] PID_GROUP_DATA      = 2'b11;
  localparam logic [1:0] PID_GROUP_HANDSHAKE = 2'b10;

  // token fields, the frame number spans address and endpoint
  localparam int unsigned ADDR_W  = 7;
  localparam int unsigned ENDP_W  = 4;
  localparam int unsigned FRAME_W = 11;

  // a register preset to ones that has taken data plus its CRC
  // ends on the fixed residue
  localparam logic [4:0]  CRC5_POLY     = 5'b00101;
  localparam logic [4:0]  CRC5_RESIDUE  = 5'b01100;
  localparam logic [15:0] CRC16_POLY    = 16'h8005;
  localparam logic [15:0] CRC16_RESIDUE = 16'h800D;

  localparam int unsigned BYTE_W = 8;

endpackage

// File: design/usb_line_recovery.sv
/*
 * Filters the raw D+/D- pair into a line state and recovers the bit clock.
 * A change of the pair costs one clock in the transition state, which also
 * realigns the bit phase so that exactly one mid-bit sample occurs per bit.
 */
`timescale 1ns/100ps

module usb_line_recovery (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    usb_dp_i,
  input  logic                    usb_dn_i,
  output usb_rx_pkg::line_state_t line_state_o,
  output logic                    sample_o,
  output logic                    bit_strobe_o
);

  localparam int unsigned PHASE_W = $clog2(usb_rx_pkg::SAMPLES_PER_BIT);

  logic [1:0]              dpair;
  usb_rx_pkg::line_state_t line_state_q, line_state_d;
  logic [PHASE_W-1:0]      bit_phase_q, bit_phase_d;

  //////////////////////////////
  // line state filter
  //////////////////////////////

  assign dpair = {usb_dp_i, usb_dn_i};

  // one of the two wires may switch a clock before the other
  // so any change first parks in the transition state
  // and the pair is taken as the new state one clock later
  always_comb begin
    line_state_d = line_state_q;
    if (line_state_q == usb_rx_pkg::LINE_DT) begin
      line_state_d = {1'b0, dpair};
    end else if (dpair != line_state_q[1:0]) begin
      line_state_d = usb_rx_pkg::LINE_DT;
    end
  end

  //////////////////////////////
  // clock recovery
  //////////////////////////////

  // the transition state marks a bit edge, so the phase restarts there
  // and then counts freely across runs without edges
  assign bit_phase_d = (line_state_q == usb_rx_pkg::LINE_DT) ? '0 : bit_phase_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_state_q <= usb_rx_pkg::LINE_SE0;
      bit_phase_q  <= '0;
    end else begin
      line_state_q <= line_state_d;
      bit_phase_q  <= bit_phase_d;
    end
  end

  // phase 1 lies mid-bit, well clear of the next edge
  assign sample_o     = (bit_phase_q == PHASE_W'(1));
  assign bit_strobe_o = (bit_phase_q == PHASE_W'(2));
  assign line_state_o = line_state_q;

endmodule

// File: design/usb_packet_ctrl.sv
/*
 * Packet control of the receiver. Finds sync and end of packet, decodes NRZI,
 * drops stuffed bits, captures and checks the PID and grades the packet at
 * its end from the PID group, the length flags and the CRC results.
 */
`timescale 1ns/100ps

module usb_packet_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  usb_rx_pkg::line_state_t      line_state_i,
  input  logic                         sample_i,
  input  logic                         crc5_match_i,
  input  logic                         crc16_match_i,
  input  logic                         len_token_ok_i,
  input  logic                         len_data_ok_i,
  input  logic                         len_hs_ok_i,
  output logic                         pkt_start_o,
  output logic                         pkt_end_o,
  output logic                         bit_valid_o,
  output logic                         bit_o,
  output logic [usb_rx_pkg::PID_W-1:0] pid_o,
  output logic                         valid_pid_o,
  output logic                         valid_packet_o,
  output logic                         pid_error_o,
  output logic                         crc5_error_o,
  output logic                         crc16_error_o,
  output logic                         bitstuff_error_o
);

  // PID and its complement plus a sentinel bit
  localparam int unsigned FULL_PID_W = 2 * usb_rx_pkg::PID_W + 1;

  logic [11:0]           line_history_q, line_history_d;
  logic                  packet_valid_q, packet_valid_d;
  logic                  see_eop, packet_start, packet_end;
  logic                  din, dvalid_raw, dvalid;
  logic [6:0]            stuff_history_q, stuff_history_d;
  logic                  bitstuff_error_q, bitstuff_error_d;
  logic [FULL_PID_W-1:0] full_pid_q, full_pid_d;
  logic                  pid_valid, pid_complete;
  logic                  pkt_is_token, pkt_is_data, pkt_is_hs;

  // true for a J or K symbol, the only ones that carry data
  function automatic logic is_jk(input logic [1:0] sym);
    return (sym == usb_rx_pkg::LINE_J[1:0]) || (sym == usb_rx_pkg::LINE_K[1:0]);
  endfunction

  //////////////////////////////
  // packet framing
  //////////////////////////////

  // two SE0 bits end a packet, and so does a stuffing violation
  assign see_eop = (line_history_q[3:0] == {2{usb_rx_pkg::LINE_SE0[1:0]}}) || bitstuff_error_q;

  always_comb begin
    packet_valid_d = packet_valid_q;
    if (sample_i) begin
      if (!packet_valid_q && (line_history_q == usb_rx_pkg::SYNC_PATTERN)) begin
        packet_valid_d = 1'b1;
      end else if (packet_valid_q && see_eop) begin
        packet_valid_d = 1'b0;
      end
    end
  end

  // the history takes one symbol per mid-bit sample
  assign line_history_d = sample_i ? {line_history_q[9:0], line_state_i[1:0]} : line_history_q;
  assign packet_start   = packet_valid_d & ~packet_valid_q;
  assign packet_end     = packet_valid_q & ~packet_valid_d;

  //////////////////////////////
  // NRZI and bit stuffing
  //////////////////////////////

  // an unchanged symbol is a one and a change is a zero
  assign din        = (line_history_q[3:2] == line_history_q[1:0]);
  assign dvalid_raw = packet_valid_q & sample_i &
                      is_jk(line_history_q[3:2]) & is_jk(line_history_q[1:0]);

  always_comb begin
    stuff_history_d = stuff_history_q;
    if (packet_end) begin
      stuff_history_d = '0;
    end else if (dvalid_raw) begin
      stuff_history_d = {stuff_history_q[5:0], din};
    end
  end

  // the bit after six ones is the stuffed zero and is dropped
  // once the error is seen no further bits go to the datapath
  assign dvalid = dvalid_raw & ~(&stuff_history_q[5:0]) & ~bitstuff_error_q;

  // seven ones in a row latch the error until the next sync
  assign bitstuff_error_d = packet_start ? 1'b0 : (bitstuff_error_q | (&stuff_history_q));

  //////////////////////////////
  // PID capture
  //////////////////////////////

  // the PID arrives low bit first and shifts down toward the sentinel
  assign pid_complete = full_pid_q[0];
  assign pid_valid    = (full_pid_q[usb_rx_pkg::PID_W:1] ==
                         ~full_pid_q[FULL_PID_W-1:usb_rx_pkg::PID_W+1]);

  always_comb begin
    full_pid_d = full_pid_q;
    if (packet_start) begin
      full_pid_d = {1'b1, {(FULL_PID_W-1){1'b0}}};
    end else if (dvalid && !pid_complete) begin
      full_pid_d = {din, full_pid_q[FULL_PID_W-1:1]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_history_q   <= usb_rx_pkg::IDLE_HISTORY;
      packet_valid_q   <= 1'b0;
      stuff_history_q  <= '0;
      bitstuff_error_q <= 1'b0;
      full_pid_q       <= '0;
    end else begin
      line_history_q   <= line_history_d;
      packet_valid_q   <= packet_valid_d;
      stuff_history_q  <= stuff_history_d;
      bitstuff_error_q <= bitstuff_error_d;
      full_pid_q       <= full_pid_d;
    end
  end

  //////////////////////////////
  // grading and outputs
  //////////////////////////////

  assign pid_o        = full_pid_q[usb_rx_pkg::PID_W:1];
  assign pkt_is_token = (pid_o[1:0] == usb_rx_pkg::PID_GROUP_TOKEN);
  assign pkt_is_data  = (pid_o[1:0] == usb_rx_pkg::PID_GROUP_DATA);
  assign pkt_is_hs    = (pid_o[1:0] == usb_rx_pkg::PID_GROUP_HANDSHAKE);

  // each group has its own length rule and only tokens and data carry a CRC
  assign valid_packet_o = pid_valid & ~bitstuff_error_q &
                          ((pkt_is_hs & len_hs_ok_i) |
                           (pkt_is_data & len_data_ok_i & crc16_match_i) |
                           (pkt_is_token & len_token_ok_i & crc5_match_i));

  assign valid_pid_o      = pid_valid;
  assign pid_error_o      = packet_end & ~pid_valid;
  assign crc5_error_o     = packet_end & pkt_is_token & ~crc5_match_i;
  assign crc16_error_o    = packet_end & pkt_is_data & ~crc16_match_i;
  assign bitstuff_error_o = packet_end & bitstuff_error_q;

  // payload bits start after the PID
  assign bit_valid_o = dvalid & pid_complete;
  assign bit_o       = din;
  assign pkt_start_o = packet_start;
  assign pkt_end_o   = packet_end;

endmodule

// File: design/usb_crc_check.sv
/*
 * Serial CRC checker. Presets to all ones on start, shifts each valid bit
 * through the polynomial and reports when the register holds the residue.
 */
`timescale 1ns/100ps

module usb_crc_check #(
  parameter int unsigned     CRC_W       = 5,
  parameter logic [CRC_W-1:0] CRC_POLY    = '0,
  parameter logic [CRC_W-1:0] CRC_RESIDUE = '0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic bit_valid_i,
  input  logic bit_i,
  output logic match_o
);

  logic [CRC_W-1:0] crc_q, crc_d;
  logic             feedback;

  // the incoming bit meets the register's top bit
  assign feedback = bit_i ^ crc_q[CRC_W-1];

  always_comb begin
    crc_d = crc_q;
    if (start_i) begin
      crc_d = '1;
    end else if (bit_valid_i) begin
      crc_d = {crc_q[CRC_W-2:0], 1'b0} ^ ({CRC_W{feedback}} & CRC_POLY);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc_q <= '0;
    end else begin
      crc_q <= crc_d;
    end
  end

  assign match_o = (crc_q == CRC_RESIDUE);

endmodule

// File: design/usb_field_deser.sv
/*
 * Payload side of the receiver. Captures token fields, assembles data bytes
 * low bit first and puts each one, and counts payload bits so the control
 * can check the length rule of each packet group.
 */
`timescale 1ns/100ps

module usb_field_deser (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           start_i,
  input  logic                           bit_valid_i,
  input  logic                           bit_i,
  input  logic [usb_rx_pkg::PID_W-1:0]   pid_i,
  output logic [usb_rx_pkg::ADDR_W-1:0]  addr_o,
  output logic [usb_rx_pkg::ENDP_W-1:0]  endp_o,
  output logic [usb_rx_pkg::FRAME_W-1:0] frame_num_o,
  output logic [usb_rx_pkg::BYTE_W-1:0]  rx_data_o,
  output logic                           rx_put_o,
  output logic                           len_token_ok_o,
  output logic                           len_data_ok_o,
  output logic                           len_hs_ok_o
);

  localparam int unsigned TOKEN_W   = usb_rx_pkg::FRAME_W;
  localparam int unsigned BYTE_W    = usb_rx_pkg::BYTE_W;
  localparam int unsigned BIT_CNT_W = $clog2(BYTE_W);

  logic                 is_token, is_data;
  logic [TOKEN_W:0]     token_q, token_d;
  logic                 token_done;
  logic [BYTE_W:0]      byte_q, byte_d;
  logic                 byte_full;
  logic [BIT_CNT_W-1:0] bit_cnt_q;
  // whole bytes seen, saturating at three
  logic [1:0]           byte_cnt_q;

  assign is_token = (pid_i[1:0] == usb_rx_pkg::PID_GROUP_TOKEN);
  assign is_data  = (pid_i[1:0] == usb_rx_pkg::PID_GROUP_DATA);

  //////////////////////////////
  // token fields
  //////////////////////////////

  // the sentinel reaches bit 0 when all eleven field bits are in
  // and the CRC5 bits that follow are left out
  assign token_done = token_q[0];

  always_comb begin
    token_d = token_q;
    if (start_i) begin
      token_d = {1'b1, {TOKEN_W{1'b0}}};
    end else if (bit_valid_i && is_token && !token_done) begin
      token_d = {bit_i, token_q[TOKEN_W:1]};
    end
  end

  //////////////////////////////
  // data bytes
  //////////////////////////////

  // a full buffer is put for one cycle and then re-armed
  assign byte_full = byte_q[0];
  assign rx_put_o  = byte_full;
  assign rx_data_o = byte_q[BYTE_W:1];

  always_comb begin
    byte_d = byte_q;
    if (start_i || byte_full) begin
      byte_d = {1'b1, {BYTE_W{1'b0}}};
    end
    if (bit_valid_i && is_data) begin
      byte_d = {bit_i, byte_q[BYTE_W:1]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      token_q     <= '0;
      byte_q      <= '0;
      bit_cnt_q   <= '0;
      byte_cnt_q  <= '0;
      addr_o      <= '0;
      endp_o      <= '0;
      frame_num_o <= '0;
    end else begin
      token_q <= token_d;
      byte_q  <= byte_d;
      if (start_i) begin
        bit_cnt_q  <= '0;
        byte_cnt_q <= '0;
      end else if (bit_valid_i) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        if (&bit_cnt_q && !(&byte_cnt_q)) begin
          byte_cnt_q <= byte_cnt_q + 1'b1;
        end
      end
      // fields follow a completed token and hold through other packets
      if (token_done && is_token) begin
        addr_o      <= token_q[usb_rx_pkg::ADDR_W:1];
        endp_o      <= token_q[TOKEN_W:usb_rx_pkg::ADDR_W+1];
        frame_num_o <= token_q[TOKEN_W:1];
      end
    end
  end

  // tokens carry exactly two bytes, data at least two whole bytes
  // and handshakes nothing after the PID
  assign len_token_ok_o = (bit_cnt_q == '0) && (byte_cnt_q == 2'd2);
  assign len_data_ok_o  = (bit_cnt_q == '0) && byte_cnt_q[1];
  assign len_hs_ok_o    = (bit_cnt_q == '0) && (byte_cnt_q == 2'd0);

endmodule

// File: design/usb_fs_receiver.sv
/*
 * Full-speed USB packet receiver top level. Connects line recovery, packet
 * control, the CRC5 and CRC16 checkers and the field deserializer.
 */
`timescale 1ns/100ps

module usb_fs_receiver (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           usb_dp_i,
  input  logic                           usb_dn_i,
  output logic                           bit_strobe_o,
  output logic                           pkt_start_o,
  output logic                           pkt_end_o,
  output logic [usb_rx_pkg::PID_W-1:0]   pid_o,
  output logic [usb_rx_pkg::ADDR_W-1:0]  addr_o,
  output logic [usb_rx_pkg::ENDP_W-1:0]  endp_o,
  output logic [usb_rx_pkg::FRAME_W-1:0] frame_num_o,
  output logic [usb_rx_pkg::BYTE_W-1:0]  rx_data_o,
  output logic                           rx_put_o,
  output logic                           valid_pid_o,
  output logic                           valid_packet_o,
  output logic                           pid_error_o,
  output logic                           crc5_error_o,
  output logic                           crc16_error_o,
  output logic                           bitstuff_error_o
);

  usb_rx_pkg::line_state_t line_state;
  logic                    sample;
  logic                    bit_valid, rx_bit;
  logic                    crc5_match, crc16_match;
  logic                    len_token_ok, len_data_ok, len_hs_ok;

  usb_line_recovery usb_line_recovery_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .usb_dp_i     (usb_dp_i),
    .usb_dn_i     (usb_dn_i),
    .line_state_o (line_state),
    .sample_o     (sample),
    .bit_strobe_o (bit_strobe_o)
  );

  usb_packet_ctrl usb_packet_ctrl_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .line_state_i     (line_state),
    .sample_i         (sample),
    .crc5_match_i     (crc5_match),
    .crc16_match_i    (crc16_match),
    .len_token_ok_i   (len_token_ok),
    .len_data_ok_i    (len_data_ok),
    .len_hs_ok_i      (len_hs_ok),
    .pkt_start_o      (pkt_start_o),
    .pkt_end_o        (pkt_end_o),
    .bit_valid_o      (bit_valid),
    .bit_o            (rx_bit),
    .pid_o            (pid_o),
    .valid_pid_o      (valid_pid_o),
    .valid_packet_o   (valid_packet_o),
    .pid_error_o      (pid_error_o),
    .crc5_error_o     (crc5_error_o),
    .crc16_error_o    (crc16_error_o),
    .bitstuff_error_o (bitstuff_error_o)
  );

  // both checkers run on every payload bit, the control picks one by group
  usb_crc_check #(
    .CRC_W       ($bits(usb_rx_pkg::CRC5_POLY)),
    .CRC_POLY    (usb_rx_pkg::CRC5_POLY),
    .CRC_RESIDUE (usb_rx_pkg::CRC5_RESIDUE)
  ) usb_crc5_check_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (pkt_start_o),
    .bit_valid_i (bit_valid),
    .bit_i       (rx_bit),
    .match_o     (crc5_match)
  );

  usb_crc_check #(
    .CRC_W       ($bits(usb_rx_pkg::CRC16_POLY)),
    .CRC_POLY    (usb_rx_pkg::CRC16_POLY),
    .CRC_RESIDUE (usb_rx_pkg::CRC16_RESIDUE)
  ) usb_crc16_check_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (pkt_start_o),
    .bit_valid_i (bit_valid),
    .bit_i       (rx_bit),
    .match_o     (crc16_match)
  );

  usb_field_deser usb_field_deser_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (pkt_start_o),
    .bit_valid_i    (bit_valid),
    .bit_i          (rx_bit),
    .pid_i          (pid_o),
    .addr_o         (addr_o),
    .endp_o         (endp_o),
    .frame_num_o    (frame_num_o),
    .rx_data_o      (rx_data_o),
    .rx_put_o       (rx_put_o),
    .len_token_ok_o (len_token_ok),
    .len_data_ok_o  (len_data_ok),
    .len_hs_ok_o    (len_hs_ok)
  );

endmodule

// File: testbench/tb_usb_fs_receiver.sv
/*
 * Testbench for the full-speed USB receiver. Builds packets bit by bit, adds CRC,
 * bit stuffing and NRZI, drives them on D+/D- and checks the DUT with assertions.
 */
`timescale 1ns/100ps

module tb_usb_fs_receiver;

  // line symbols as {dp, dn}
  localparam logic [1:0] SYM_J       = 2'b10;
  localparam logic [1:0] SYM_K       = 2'b01;
  localparam logic [1:0] SYM_SE0     = 2'b00;
  localparam int         END_TIMEOUT = 100;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           usb_dp_i;
  logic                           usb_dn_i;
  logic                           bit_strobe_o;
  logic                           pkt_start_o;
  logic                           pkt_end_o;
  logic [usb_rx_pkg::PID_W-1:0]   pid_o;
  logic [usb_rx_pkg::ADDR_W-1:0]  addr_o;
  logic [usb_rx_pkg::ENDP_W-1:0]  endp_o;
  logic [usb_rx_pkg::FRAME_W-1:0] frame_num_o;
  logic [usb_rx_pkg::BYTE_W-1:0]  rx_data_o;
  logic                           rx_put_o;
  logic                           valid_pid_o;
  logic                           valid_packet_o;
  logic                           pid_error_o;
  logic                           crc5_error_o;
  logic                           crc16_error_o;
  logic                           bitstuff_error_o;

  // packet bits after sync and before stuffing with each field low bit first
  bit          pkt_bits[$];
  logic [7:0]  exp_bytes[$];
  logic [1:0]  line_level;
  logic [31:0] lcg_state;
  logic [15:0] rand_word;
  logic [3:0]  exp_pid;
  logic [6:0]  exp_addr;
  logic [3:0]  exp_endp;
  logic [10:0] exp_frame;
  logic        check_token, check_frame;
  logic        exp_valid, exp_pid_err, exp_crc5_err, exp_crc16_err, exp_stuff_err;
  logic        in_packet;
  int          end_count, error_count, errors_before, test_count, failed_tests;
  int          strobe_gap;

  usb_fs_receiver usb_fs_receiver_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .usb_dp_i         (usb_dp_i),
    .usb_dn_i         (usb_dn_i),
    .bit_strobe_o     (bit_strobe_o),
    .pkt_start_o      (pkt_start_o),
    .pkt_end_o        (pkt_end_o),
    .pid_o            (pid_o),
    .addr_o           (addr_o),
    .endp_o           (endp_o),
    .frame_num_o      (frame_num_o),
    .rx_data_o        (rx_data_o),
    .rx_put_o         (rx_put_o),
    .valid_pid_o      (valid_pid_o),
    .valid_packet_o   (valid_packet_o),
    .pid_error_o      (pid_error_o),
    .crc5_error_o     (crc5_error_o),
    .crc16_error_o    (crc16_error_o),
    .bitstuff_error_o (bitstuff_error_o)
  );

  // 40 ns clock period
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
    $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    error_count++;
  endtask

  task automatic report_failure(input string what);
    $display("failure at %0t: %s", $time, what);
    error_count++;
  endtask

  //////////////////////////////
  // assertions
  //////////////////////////////

  // outputs are checked at the falling edge half a cycle clear of any change
  always @(negedge clk_i) begin
    if (rst_ni && pkt_end_o) begin
      end_count++;
      assert (valid_packet_o == exp_valid)
        else report_mismatch("valid_packet_o", 16'(valid_packet_o), 16'(exp_valid));
      assert (valid_pid_o == !exp_pid_err)
        else report_mismatch("valid_pid_o", 16'(valid_pid_o), 16'(!exp_pid_err));
      assert (pid_error_o == exp_pid_err)
        else report_mismatch("pid_error_o", 16'(pid_error_o), 16'(exp_pid_err));
      assert (crc5_error_o == exp_crc5_err)
        else report_mismatch("crc5_error_o", 16'(crc5_error_o), 16'(exp_crc5_err));
      assert (crc16_error_o == exp_crc16_err)
        else report_mismatch("crc16_error_o", 16'(crc16_error_o), 16'(exp_crc16_err));
      assert (bitstuff_error_o == exp_stuff_err)
        else report_mismatch("bitstuff_error_o", 16'(bitstuff_error_o), 16'(exp_stuff_err));
      assert (pid_o == exp_pid) else report_mismatch("pid_o", 16'(pid_o), 16'(exp_pid));
      if (check_token) begin
        assert (addr_o == exp_addr) else report_mismatch("addr_o", 16'(addr_o), 16'(exp_addr));
        assert (endp_o == exp_endp) else report_mismatch("endp_o", 16'(endp_o), 16'(exp_endp));
      end
      if (check_frame) begin
        assert (frame_num_o == exp_frame)
          else report_mismatch("frame_num_o", 16'(frame_num_o), 16'(exp_frame));
      end
    end
    // error outputs are pulses that only come with the end of a packet
    if (rst_ni && !pkt_end_o) begin
      assert (!(pid_error_o || crc5_error_o || crc16_error_o || bitstuff_error_o))
        else report_failure("an error output pulsed outside pkt_end_o");
    end
  end

  // every put must match the oldest byte still expected
  always @(negedge clk_i) begin
    if (rst_ni && rx_put_o) begin
      assert (exp_bytes.size() > 0) else report_failure("rx_put_o pulsed with no byte expected");
      if (exp_bytes.size() > 0) begin
        assert (rx_data_o == exp_bytes[0])
          else report_mismatch("rx_data_o", 16'(rx_data_o), 16'(exp_bytes[0]));
        void'(exp_bytes.pop_front());
      end
    end
  end

  // each pkt_end_o closes a packet that one pkt_start_o opened
  always @(negedge clk_i) begin
    if (rst_ni && pkt_start_o) begin
      assert (!in_packet)
        else report_failure("pkt_start_o pulsed again before pkt_end_o");
      in_packet = 1'b1;
    end
    if (rst_ni && pkt_end_o) begin
      assert (in_packet)
        else report_failure("pkt_end_o pulsed with no pkt_start_o before it");
      in_packet = 1'b0;
    end
  end

  // the recovered bit clock strobes once per bit period
  always @(negedge clk_i) begin
    if (rst_ni && bit_strobe_o) begin
      if (strobe_gap > 0) begin
        assert (strobe_gap == usb_rx_pkg::SAMPLES_PER_BIT)
          else report_mismatch("bit_strobe_o period", 16'(strobe_gap),
                               16'(usb_rx_pkg::SAMPLES_PER_BIT));
      end
      strobe_gap = 1;
    end else if (rst_ni && strobe_gap > 0) begin
      strobe_gap++;
    end
  end

  //////////////////////////////
  // packet building
  //////////////////////////////

  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic push_field(input logic [15:0] value, input int width);
    for (int i = 0; i < width; i++) begin
      pkt_bits.push_back(value[i]);
    end
  endtask

  // the PID goes out with its complement in the upper nibble
  task automatic push_pid(input logic [3:0] pid);
    push_field({8'h00, ~pid, pid}, 8);
  endtask

  // the CRC covers the bits after the PID and goes out inverted with the top bit first
  // x^5+x^2+1 for tokens and x^16+x^15+x^2+1 for data
  task automatic append_crc(input int width);
    logic [15:0] crc;
    logic [15:0] poly;
    logic        fb;
    crc  = 16'hFFFF;
    poly = (width == 5) ? 16'h0005 : 16'h8005;
    for (int i = 8; i < pkt_bits.size(); i++) begin
      fb  = pkt_bits[i] ^ crc[width-1];
      crc = (crc << 1) ^ (fb ? poly : 16'h0000);
    end
    for (int i = width - 1; i >= 0; i--) begin
      pkt_bits.push_back(!crc[i]);
    end
  endtask

  // every eight bits after the PID form a byte and the CRC16 bytes count too
  task automatic queue_data_bytes();
    logic [7:0] b;
    for (int i = 8; i + 8 <= pkt_bits.size(); i += 8) begin
      for (int j = 0; j < 8; j++) begin
        b[j] = pkt_bits[i+j];
      end
      exp_bytes.push_back(b);
    end
  endtask

  task automatic expect_result(input logic [3:0] pid, input logic valid, input logic pid_err,
                               input logic crc5_err, input logic crc16_err,
                               input logic stuff_err);
    exp_pid       = pid;
    exp_valid     = valid;
    exp_pid_err   = pid_err;
    exp_crc5_err  = crc5_err;
    exp_crc16_err = crc16_err;
    exp_stuff_err = stuff_err;
  endtask

  //////////////////////////////
  // line driver
  //////////////////////////////

  // pins change 2 ns after a rising edge and hold for one bit
  task automatic drive_symbol(input logic [1:0] sym);
    {usb_dp_i, usb_dn_i} = sym;
    repeat (usb_rx_pkg::SAMPLES_PER_BIT) @(posedge clk_i);
    #2;
  endtask

  // in NRZI a zero toggles the line and a one holds it
  task automatic send_nrzi(input bit b);
    if (!b) begin
      line_level = (line_level == SYM_J) ? SYM_K : SYM_J;
    end
    drive_symbol(line_level);
  endtask

  task automatic send_packet(input bit stuff_en);
    int ones;
    ones       = 0;
    line_level = SYM_J;
    // sync is seven zeros and a one
    repeat (7) send_nrzi(1'b0);
    send_nrzi(1'b1);
    // the run of ones is counted from the first PID bit on
    foreach (pkt_bits[i]) begin
      send_nrzi(pkt_bits[i]);
      ones = pkt_bits[i] ? ones + 1 : 0;
      if (stuff_en && ones == 6) begin
        send_nrzi(1'b0);
        ones = 0;
      end
    end
    drive_symbol(SYM_SE0);
    drive_symbol(SYM_SE0);
    line_level = SYM_J;
    repeat (3) drive_symbol(SYM_J);
  endtask

  task automatic run_packet(input bit stuff_en);
    int ends_before;
    int cycles;
    ends_before = end_count;
    cycles      = 0;
    send_packet(stuff_en);
    while (end_count == ends_before && cycles < END_TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (cycles > 0) begin
      #2;
    end
    assert (end_count != ends_before) else report_failure("no pkt_end_o after the packet");
    assert (exp_bytes.size() == 0) else report_failure("expected bytes were never put");
    exp_bytes.delete();
    pkt_bits.delete();
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (error_count > errors_before) begin
      failed_tests++;
      $display("test %0d %s: fail", test_count, name);
    end else begin
      $display("test %0d %s: pass", test_count, name);
    end
    errors_before = error_count;
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    rst_ni        = 1'b0;
    usb_dp_i      = 1'b1;
    usb_dn_i      = 1'b0;
    line_level    = SYM_J;
    lcg_state     = 32'd79;
    end_count     = 0;
    error_count   = 0;
    errors_before = 0;
    test_count    = 0;
    failed_tests  = 0;
    strobe_gap    = 0;
    in_packet     = 1'b0;
    check_token   = 1'b0;
    check_frame   = 1'b0;
    exp_addr      = '0;
    exp_endp      = '0;
    exp_frame     = '0;
    expect_result(4'b0000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

    repeat (2) @(posedge clk_i);
    assert (!pkt_start_o && !pkt_end_o && !rx_put_o && !bit_strobe_o && !pid_error_o &&
            !crc5_error_o && !crc16_error_o && !bitstuff_error_o && addr_o == '0 &&
            endp_o == '0 && frame_num_o == '0)
      else report_failure("outputs not cleared during reset");
    #2;
    rst_ni = 1'b1;
    finish_test("reset values");
    repeat (4) drive_symbol(SYM_J);

    // OUT token to a chosen address and endpoint
    exp_addr    = 7'h3A;
    exp_endp    = 4'h5;
    check_token = 1'b1;
    push_pid(4'b0001);
    push_field(16'(exp_addr), 7);
    push_field(16'(exp_endp), 4);
    append_crc(5);
    expect_result(4'b0001, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    run_packet(1'b1);
    check_token = 1'b0;
    finish_test("OUT token");

    // SOF with a random frame number
    rand_word   = {rand_byte(), rand_byte()};
    exp_frame   = rand_word[10:0];
    check_frame = 1'b1;
    push_pid(4'b0101);
    push_field(16'(exp_frame), 11);
    append_crc(5);
    expect_result(4'b0101, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    run_packet(1'b1);
    check_frame = 1'b0;
    finish_test("SOF frame number");

    // DATA0 with four random bytes
    push_pid(4'b0011);
    repeat (4) push_field(16'(rand_byte()), 8);
    append_crc(16);
    queue_data_bytes();
    expect_result(4'b0011, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    run_packet(1'b1);
    finish_test("DATA0 bytes");

    // one CRC16 bit inverted on the way out
    push_pid(4'b1011);
    repeat (3) push_field(16'(rand_byte()), 8);
    append_crc(16);
    pkt_bits[pkt_bits.size()-5] = !pkt_bits[pkt_bits.size()-5];
    queue_data_bytes();
    expect_result(4'b1011, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    run_packet(1'b1);
    finish_test("DATA1 bad CRC16");

    // ACK code with an upper nibble that is not its complement
    push_field(16'h0022, 8);
    expect_result(4'b0010, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    run_packet(1'b1);
    finish_test("bad PID check");

    push_pid(4'b0010);
    expect_result(4'b0010, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    run_packet(1'b1);
    // the ACK ends in two ones so an unstuffed 0xFF makes a run of seven
    push_pid(4'b0010);
    push_field(16'h00FF, 8);
    expect_result(4'b0010, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    run_packet(1'b0);
    finish_test("ACK and stuffing error");

    $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: sim.f
design/usb_rx_pkg.sv
design/usb_line_recovery.sv
design/usb_packet_ctrl.sv
design/usb_crc_check.sv
design/usb_field_deser.sv
design/usb_fs_receiver.sv
testbench/tb_usb_fs_receiver.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_usb_fs_receiver
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Finished with no errors
COMMON     := --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary --assert -Wno-fatal --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
